//--- hw/lsu_isa_pkg.sv
package lsu_isa_pkg;

    // ALE doubles as the idle code when no exception is pending.
    typedef enum logic [2:0] {
        ALE,  // address not aligned to the access size.
        TLBR, // no translation for the address.
        PIL,  // load hit an invalid page.
        PIS,  // store hit an invalid page.
        PPI,  // privilege level too low for the page.
        PME   // store to a read-only page.
    } exception_t;

    typedef enum logic [1:0] {
        MEM_NOP,
        MEM_LOAD,
        MEM_STORE
    } mem_type_t;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_t;

endpackage

//--- hw/lsu_pipe_pkg.sv
package lsu_pipe_pkg;

    // payload handed over from the execute stage.
    typedef struct packed {
        logic [31:0]             pc;
        logic                    have_exception;
        lsu_isa_pkg::exception_t exception_type;
        logic [31:0]             result; // carries the effective address for loads and stores.
        logic [4:0]              dest;
        lsu_isa_pkg::mem_type_t  mem_type;
        lsu_isa_pkg::mem_size_t  mem_size;
        logic                    ld_unsigned;
        logic [31:0]             st_data;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0]             pc;
        logic                    have_exception;
        lsu_isa_pkg::exception_t exception_type;
        logic [31:0]             result;
        logic [4:0]              dest;
        lsu_isa_pkg::mem_type_t  mem_type;
        lsu_isa_pkg::mem_size_t  mem_size;
        logic                    ld_unsigned;
    } mem_wb_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic        we;
        logic [1:0]  size;  // log2 of the access width in bytes.
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        addr_ok;
        logic [31:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic tlbr;
        logic pil;
        logic pis;
        logic ppi;
        logic pme;
    } fault_t;

endpackage

//--- hw/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     stall,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0; // a flush drops whatever the stage holds.
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_data <= in_data;
        end
    end

endmodule

//--- hw/addr_check.sv
`timescale 1ns/1ps

module addr_check #(
    parameter int unsigned RAM_WORDS = 256,
    parameter logic [31:0] RO_BASE   = 32'h0000_0300,
    parameter logic [31:0] RO_SIZE   = 32'h0000_0040,
    parameter logic [31:0] KERN_BASE = 32'h0000_0200,
    parameter logic [31:0] KERN_SIZE = 32'h0000_0080,
    parameter logic [31:0] INV_BASE  = 32'h0000_0380,
    parameter logic [31:0] INV_SIZE  = 32'h0000_0040
) (
    input  logic [31:0]            addr,
    input  lsu_isa_pkg::mem_type_t mem_type,
    input  logic [1:0]             plv,
    output lsu_pipe_pkg::fault_t   fault
);
    import lsu_isa_pkg::*;

    localparam logic [31:0] RAM_BYTES = 32'(RAM_WORDS * 4);

    logic is_load;
    logic is_store;
    logic active;
    logic in_ro;
    logic in_kern;
    logic in_inv;

    function automatic logic in_window(input logic [31:0] a,
                                       input logic [31:0] base,
                                       input logic [31:0] size);
        return (a >= base) && ((a - base) < size);
    endfunction

    assign is_load  = mem_type == MEM_LOAD;
    assign is_store = mem_type == MEM_STORE;
    assign active   = is_load || is_store; // a NOP never faults.

    assign in_ro   = in_window(addr, RO_BASE, RO_SIZE);
    assign in_kern = in_window(addr, KERN_BASE, KERN_SIZE);
    assign in_inv  = in_window(addr, INV_BASE, INV_SIZE);

    assign fault.tlbr = active && addr >= RAM_BYTES;
    assign fault.pil  = is_load && in_inv;
    assign fault.pis  = is_store && in_inv;
    assign fault.ppi  = active && in_kern && plv == 2'd3; // user mode may not touch kernel pages.
    assign fault.pme  = is_store && in_ro;

endmodule

//--- hw/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int unsigned RAM_WORDS = 256
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lsu_pipe_pkg::mem_req_t req,
    output lsu_pipe_pkg::mem_rsp_t rsp,
    input  logic                   rsp_taken
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    logic [31:0]   rdata_q;
    logic          busy;
    logic          accept;
    logic [AW-1:0] idx;

    assign idx    = req.addr[AW+1:2];
    assign accept = req.valid && rsp.addr_ok;

    // the port frees up in the same cycle the pending read word is taken.
    assign rsp.addr_ok = !busy || rsp_taken;
    assign rsp.rdata   = rdata_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (accept && !req.we) begin
            busy <= 1'b1;
        end else if (rsp_taken) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (req.wstrb[i]) begin
                    mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
        if (accept && !req.we) begin
            rdata_q <= mem[idx]; // held until the next accepted read.
        end
    end

endmodule

//--- hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   ex_valid,
    input  lsu_pipe_pkg::ex_mem_t  ex_data,
    input  logic                   allowout,
    output logic                   ex_allowin,
    output logic                   mem_valid,
    output lsu_pipe_pkg::mem_wb_t  mem_data,
    output lsu_pipe_pkg::mem_req_t req,
    input  logic                   addr_ok,
    input  lsu_pipe_pkg::fault_t   fault
);
    import lsu_isa_pkg::*;
    import lsu_pipe_pkg::*;

    ex_mem_t    stage;
    logic       stage_valid;
    logic       stall;
    logic       mem_ready;
    logic       waiting;
    logic       misaligned;
    logic       have_exc;
    exception_t exc_type;
    logic       issue;

    pipe_reg #(
        .payload_t(ex_mem_t)
    ) u_mem_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .stall     (stall),
        .in_valid  (ex_valid),
        .in_data   (ex_data),
        .out_valid (stage_valid),
        .out_data  (stage)
    );

    // the stage is done once its access is accepted, or when it needs none.
    assign mem_ready = stage_valid && (have_exc || stage.mem_type == MEM_NOP ||
                                       (req.valid && addr_ok) || waiting);
    assign stall      = stage_valid && (!mem_ready || !allowout);
    assign ex_allowin = !stall;
    assign mem_valid  = mem_ready;

    assign misaligned = (stage.mem_size == MEM_HALF && stage.result[0]) ||
                        (stage.mem_size == MEM_WORD && stage.result[1:0] != 2'b00);

    always_comb begin
        if (stage.mem_type == MEM_NOP || stage.have_exception) begin
            have_exc = stage.have_exception;
            exc_type = stage.exception_type;
        end else if (misaligned) begin
            have_exc = 1'b1;
            exc_type = ALE;
        end else if (fault.tlbr) begin
            have_exc = 1'b1;
            exc_type = TLBR;
        end else if (fault.pil) begin
            have_exc = 1'b1;
            exc_type = PIL;
        end else if (fault.pis) begin
            have_exc = 1'b1;
            exc_type = PIS;
        end else if (fault.ppi) begin
            have_exc = 1'b1;
            exc_type = PPI;
        end else if (fault.pme) begin
            have_exc = 1'b1;
            exc_type = PME;
        end else begin
            have_exc = 1'b0;
            exc_type = ALE;
        end
    end

    assign issue = stage_valid && stage.mem_type != MEM_NOP && !have_exc;

    // set when the RAM took the access but the next stage was not ready for it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waiting <= 1'b0;
        end else if (flush) begin
            waiting <= 1'b0;
        end else if (req.valid && addr_ok && !allowout) begin
            waiting <= 1'b1;
        end else if (allowout) begin
            waiting <= 1'b0;
        end
    end

    always_comb begin
        req.valid = issue && !waiting && !flush; // nothing new reaches the RAM during a flush.
        req.addr  = stage.result;
        case (stage.mem_size)
            MEM_BYTE: req.size = 2'd0;
            MEM_HALF: req.size = 2'd1;
            default:  req.size = 2'd2;
        endcase
        req.we    = issue && stage.mem_type == MEM_STORE;
        req.wstrb = 4'b0000;
        req.wdata = stage.st_data;
        if (req.we) begin
            case (stage.mem_size)
                MEM_BYTE: begin
                    req.wstrb = 4'b0001 << stage.result[1:0];
                    req.wdata = {4{stage.st_data[7:0]}};
                end
                MEM_HALF: begin
                    req.wstrb = stage.result[1] ? 4'b1100 : 4'b0011;
                    req.wdata = {2{stage.st_data[15:0]}};
                end
                default: begin
                    req.wstrb = 4'b1111;
                end
            endcase
        end
    end

    always_comb begin
        mem_data.pc             = stage.pc;
        mem_data.have_exception = have_exc;
        mem_data.exception_type = exc_type;
        mem_data.result         = stage.result;
        mem_data.dest           = stage.dest;
        mem_data.mem_type       = stage.mem_type;
        mem_data.mem_size       = stage.mem_size;
        mem_data.ld_unsigned    = stage.ld_unsigned;
    end

endmodule

//--- hw/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    in_valid,
    input  lsu_pipe_pkg::mem_wb_t   in_data,
    input  logic [31:0]             rdata,
    output logic                    allowin,
    output logic                    rsp_taken,
    output logic                    wb_valid,
    input  logic                    wb_ready,
    output logic [31:0]             wb_pc,
    output logic [4:0]              wb_dest,
    output logic [31:0]             wb_result,
    output logic                    wb_have_exception,
    output lsu_isa_pkg::exception_t wb_exception_type
);
    import lsu_isa_pkg::*;
    import lsu_pipe_pkg::*;

    mem_wb_t     wb_data;
    logic        load_enter;
    logic        fresh;
    logic [31:0] held;
    logic [31:0] word;
    logic [31:0] shifted;
    logic [31:0] load_val;

    assign allowin = !wb_valid || wb_ready;

    pipe_reg #(
        .payload_t(mem_wb_t)
    ) u_wb_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .stall     (!allowin),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (wb_valid),
        .out_data  (wb_data)
    );

    assign load_enter = allowin && in_valid && !flush &&
                        in_data.mem_type == MEM_LOAD && !in_data.have_exception;

    // the RAM word is valid in the first cycle after a load enters.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fresh <= 1'b0;
        end else begin
            fresh <= load_enter;
        end
    end

    always_ff @(posedge clk) begin
        if (fresh) begin
            held <= rdata;
        end
    end

    assign rsp_taken = fresh || flush; // a flush also drops a read left in flight.
    assign word      = fresh ? rdata : held;
    assign shifted   = word >> {wb_data.result[1:0], 3'b000};

    always_comb begin
        case (wb_data.mem_size)
            MEM_BYTE: load_val = wb_data.ld_unsigned ? {24'b0, shifted[7:0]} :
                                                       {{24{shifted[7]}}, shifted[7:0]};
            MEM_HALF: load_val = wb_data.ld_unsigned ? {16'b0, shifted[15:0]} :
                                                       {{16{shifted[15]}}, shifted[15:0]};
            default:  load_val = word;
        endcase
    end

    assign wb_pc             = wb_data.pc;
    assign wb_dest           = wb_data.dest;
    assign wb_have_exception = wb_data.have_exception;
    assign wb_exception_type = wb_data.exception_type;
    assign wb_result = (wb_data.mem_type == MEM_LOAD && !wb_data.have_exception) ?
                       load_val : wb_data.result;

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
    parameter int unsigned RAM_WORDS = 256,
    parameter logic [31:0] RO_BASE   = 32'h0000_0300,
    parameter logic [31:0] RO_SIZE   = 32'h0000_0040,
    parameter logic [31:0] KERN_BASE = 32'h0000_0200,
    parameter logic [31:0] KERN_SIZE = 32'h0000_0080,
    parameter logic [31:0] INV_BASE  = 32'h0000_0380,
    parameter logic [31:0] INV_SIZE  = 32'h0000_0040
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic [1:0]              plv,
    input  logic                    ex_valid,
    input  lsu_pipe_pkg::ex_mem_t   ex_data,
    output logic                    ex_allowin,
    input  logic                    wb_ready,
    output logic                    wb_valid,
    output logic [31:0]             wb_pc,
    output logic [4:0]              wb_dest,
    output logic [31:0]             wb_result,
    output logic                    wb_have_exception,
    output lsu_isa_pkg::exception_t wb_exception_type
);
    import lsu_pipe_pkg::*;

    logic     mem_valid;
    mem_wb_t  mem_data;
    mem_req_t req;
    mem_rsp_t rsp;
    fault_t   fault;
    logic     wb_allowin;
    logic     rsp_taken;

    mem_stage u_mem_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .ex_valid   (ex_valid),
        .ex_data    (ex_data),
        .allowout   (wb_allowin),
        .ex_allowin (ex_allowin),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data),
        .req        (req),
        .addr_ok    (rsp.addr_ok),
        .fault      (fault)
    );

    addr_check #(
        .RAM_WORDS (RAM_WORDS),
        .RO_BASE   (RO_BASE),
        .RO_SIZE   (RO_SIZE),
        .KERN_BASE (KERN_BASE),
        .KERN_SIZE (KERN_SIZE),
        .INV_BASE  (INV_BASE),
        .INV_SIZE  (INV_SIZE)
    ) u_addr_check (
        .addr     (req.addr),
        .mem_type (mem_data.mem_type),
        .plv      (plv),
        .fault    (fault)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_data_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .rsp       (rsp),
        .rsp_taken (rsp_taken)
    );

    wb_stage u_wb_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .flush             (flush),
        .in_valid          (mem_valid),
        .in_data           (mem_data),
        .rdata             (rsp.rdata),
        .allowin           (wb_allowin),
        .rsp_taken         (rsp_taken),
        .wb_valid          (wb_valid),
        .wb_ready          (wb_ready),
        .wb_pc             (wb_pc),
        .wb_dest           (wb_dest),
        .wb_result         (wb_result),
        .wb_have_exception (wb_have_exception),
        .wb_exception_type (wb_exception_type)
    );

endmodule

//--- sim/lsu_sva.sv
`timescale 1ns/1ps

module lsu_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   flush,
    input logic                   waiting,
    input logic                   stage_valid,
    input lsu_pipe_pkg::mem_req_t req
);

    int unsigned fail_count = 0;

    // an access parked for the next stage must not reach the RAM a second time.
    no_reissue: assert property (@(posedge clk) disable iff (!rst_n)
        waiting |-> !req.valid)
        else begin
            fail_count++;
            $error("memory request raised while an accepted access waits for writeback");
        end

    strobe_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !req.we |-> req.wstrb == 4'b0000)
        else begin
            fail_count++;
            $error("byte strobes active without write enable");
        end

    flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !stage_valid)
        else begin
            fail_count++;
            $error("memory stage still valid in the cycle after a flush");
        end

endmodule

bind mem_stage lsu_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .waiting     (waiting),
    .stage_valid (stage_valid),
    .req         (req)
);

//--- sim/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
    import lsu_isa_pkg::*;
    import lsu_pipe_pkg::*;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 10;
    localparam int unsigned RAM_WORDS    = 256;
    localparam logic [31:0] RO_BASE      = 32'h0000_0300;
    localparam logic [31:0] RO_SIZE      = 32'h0000_0040;
    localparam logic [31:0] KERN_BASE    = 32'h0000_0200;
    localparam logic [31:0] KERN_SIZE    = 32'h0000_01c0; // overlaps the read-only and invalid windows.
    localparam logic [31:0] INV_BASE     = 32'h0000_0380;
    localparam logic [31:0] INV_SIZE     = 32'h0000_0040;
    localparam int          N_FILL       = 192; // word stores over 0x000 to 0x2ff.
    localparam int          N_DIRECTED   = 64;
    localparam int          N_RANDOM     = 300;
    localparam int          N_TOTAL      = 2 * N_FILL + N_DIRECTED + N_RANDOM;
    localparam int          DRAWS        = 1024;

    typedef struct packed {
        logic [31:0] pc;
        logic        have_exception;
        exception_t  exception_type;
        logic [31:0] result;
        logic [4:0]  dest;
    } expect_t;

    logic         clk = 1'b0;
    logic         rst_n = 1'b0;
    logic         flush = 1'b0;
    logic [1:0]   plv = 2'd0;
    logic         ex_valid = 1'b0;
    ex_mem_t      ex_data = '0;
    logic         ex_allowin;
    logic         wb_ready = 1'b0;
    logic         wb_valid;
    logic [31:0]  wb_pc;
    logic [4:0]   wb_dest;
    logic [31:0]  wb_result;
    logic         wb_have_exception;
    exception_t   wb_exception_type;

    logic [7:0]   shadow [1024]; // byte image of the RAM in program order.
    expect_t      exp_q [$];
    byte unsigned ready_draw [DRAWS];
    int           ready_pct = 100;
    int           cycle = 0;
    int           value_errors = 0;
    int           flow_errors = 0;
    logic [31:0]  next_pc = 32'h1c00_0000;

    lsu_top #(
        .RAM_WORDS (RAM_WORDS),
        .RO_BASE   (RO_BASE),
        .RO_SIZE   (RO_SIZE),
        .KERN_BASE (KERN_BASE),
        .KERN_SIZE (KERN_SIZE),
        .INV_BASE  (INV_BASE),
        .INV_SIZE  (INV_SIZE)
    ) u_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .flush             (flush),
        .plv               (plv),
        .ex_valid          (ex_valid),
        .ex_data           (ex_data),
        .ex_allowin        (ex_allowin),
        .wb_ready          (wb_ready),
        .wb_valid          (wb_valid),
        .wb_pc             (wb_pc),
        .wb_dest           (wb_dest),
        .wb_result         (wb_result),
        .wb_have_exception (wb_have_exception),
        .wb_exception_type (wb_exception_type)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        cycle++;
        wb_ready = ready_draw[cycle % DRAWS] < ready_pct;
    end

    function automatic bit in_win(input logic [31:0] a, input logic [31:0] base,
                                  input logic [31:0] size);
        return a >= base && a < base + size;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h0019_660d) ^ {a[15:0], ~a[15:0]};
    endfunction

    // expected retirement of one instruction, with stores applied to the shadow image.
    function automatic expect_t predict(input ex_mem_t d);
        expect_t     e;
        int          nbytes;
        logic [31:0] a;
        logic [31:0] v;
        a = d.result;
        case (d.mem_size)
            MEM_BYTE: nbytes = 1;
            MEM_HALF: nbytes = 2;
            default:  nbytes = 4;
        endcase
        e.pc = d.pc;
        e.dest = d.dest;
        e.result = a;
        e.have_exception = 1'b1;
        e.exception_type = ALE;
        if (d.have_exception) begin
            e.exception_type = d.exception_type;
        end else if (d.mem_type == MEM_NOP) begin
            e.have_exception = 1'b0;
        end else if (a % nbytes != 0) begin
            e.exception_type = ALE;
        end else if (a >= RAM_WORDS * 4) begin
            e.exception_type = TLBR;
        end else if (in_win(a, INV_BASE, INV_SIZE)) begin
            e.exception_type = (d.mem_type == MEM_LOAD) ? PIL : PIS;
        end else if (plv == 2'd3 && in_win(a, KERN_BASE, KERN_SIZE)) begin
            e.exception_type = PPI;
        end else if (d.mem_type == MEM_STORE && in_win(a, RO_BASE, RO_SIZE)) begin
            e.exception_type = PME;
        end else begin
            e.have_exception = 1'b0;
            v = '0;
            for (int i = 0; i < nbytes; i++) begin
                if (d.mem_type == MEM_STORE) begin
                    shadow[a + i] = d.st_data[8*i +: 8];
                end else begin
                    v[8*i +: 8] = shadow[a + i];
                end
            end
            if (!d.ld_unsigned && nbytes < 4 && v[8*nbytes-1]) begin
                v = v | (32'hffff_ffff << (8 * nbytes)); // sign fill above the loaded bytes.
            end
            if (d.mem_type == MEM_LOAD) begin
                e.result = v;
            end
        end
        return e;
    endfunction

    function automatic ex_mem_t build(input mem_type_t t, input mem_size_t s,
                                      input logic [31:0] addr, input logic [31:0] sdata,
                                      input logic uns);
        ex_mem_t d;
        d = '0;
        d.exception_type = ALE;
        d.mem_type = t;
        d.mem_size = s;
        d.result = addr;
        d.st_data = sdata;
        d.ld_unsigned = uns;
        return d;
    endfunction

    task automatic send(input ex_mem_t d);
        bit taken;
        d.pc = next_pc;
        d.dest = next_pc[6:2];
        next_pc = next_pc + 4;
        ex_valid = 1'b1;
        ex_data = d;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = ex_allowin;
        end
        exp_q.push_back(predict(d));
        @(negedge clk);
        ex_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() > 0) begin
            @(negedge clk);
        end
    endtask

    task automatic flush_pipe();
        flush = 1'b1;
        exp_q.delete(); // whatever is in flight now must never retire.
        @(negedge clk);
        flush = 1'b0;
        assert (!wb_valid) else begin
            flow_errors++;
            $display("wb_valid is still high in the cycle after the flush");
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            value_errors++;
            $display("[ERROR] %s at pc %h: got %h, expected %h", name, wb_pc, got, want);
        end
    endtask

    always @(posedge clk) begin : compare
        expect_t e;
        if (rst_n && wb_valid && wb_ready) begin
            assert (exp_q.size() > 0) else begin
                flow_errors++;
                $display("an instruction at pc %h retired with none outstanding", wb_pc);
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                check_value("wb_pc", wb_pc, e.pc);
                check_value("wb_dest", 32'(wb_dest), 32'(e.dest));
                check_value("wb_have_exception", 32'(wb_have_exception), 32'(e.have_exception));
                check_value("wb_exception_type", 32'(wb_exception_type), 32'(e.exception_type));
                check_value("wb_result", wb_result, e.result);
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + 16 * N_TOTAL)); // generous budget per instruction.
        $display("watchdog expired with %0d instructions outstanding", exp_q.size());
        $display("errors: value %0d, flow %0d, assertion %0d", value_errors, flow_errors,
                 u_dut.u_mem_stage.u_sva.fail_count);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : stimulus
        ex_mem_t d;
        void'($urandom(37439));
        for (int i = 0; i < DRAWS; i++) begin
            ready_draw[i] = $urandom_range(99);
        end
        repeat (RESET_CYCLES) @(negedge clk);
        assert (ex_allowin && !wb_valid && !u_dut.req.valid && !u_dut.req.we) else begin
            flow_errors++;
            $display("outputs are not idle while reset is held");
        end
        rst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < N_FILL; i++) begin
            send(build(MEM_STORE, MEM_WORD, 4 * i, fill_word(4 * i), 1'b0));
        end

        ready_pct = 70;
        send(build(MEM_STORE, MEM_WORD, 32'h40, 32'h8123_45f6, 1'b0));
        send(build(MEM_STORE, MEM_HALF, 32'h46, 32'h0000_9abc, 1'b0));
        send(build(MEM_STORE, MEM_BYTE, 32'h45, 32'h0000_0080, 1'b0));
        for (int i = 0; i < 8; i++) begin
            send(build(MEM_LOAD, MEM_BYTE, 32'h40 + i, 32'h0, 1'b0));
            send(build(MEM_LOAD, MEM_BYTE, 32'h40 + i, 32'h0, 1'b1));
        end
        for (int i = 0; i < 8; i += 2) begin
            send(build(MEM_LOAD, MEM_HALF, 32'h40 + i, 32'h0, 1'b0));
            send(build(MEM_LOAD, MEM_HALF, 32'h40 + i, 32'h0, 1'b1));
        end
        send(build(MEM_LOAD, MEM_WORD, 32'h40, 32'h0, 1'b0));
        send(build(MEM_LOAD, MEM_WORD, 32'h44, 32'h0, 1'b0));

        send(build(MEM_LOAD, MEM_HALF, 32'h41, 32'h0, 1'b0));
        send(build(MEM_LOAD, MEM_WORD, 32'h42, 32'h0, 1'b0));
        send(build(MEM_STORE, MEM_WORD, 32'h43, 32'hdead_beef, 1'b0));
        send(build(MEM_STORE, MEM_HALF, 32'h45, 32'hdead_beef, 1'b0));
        send(build(MEM_LOAD, MEM_WORD, 32'h40, 32'h0, 1'b0));
        send(build(MEM_LOAD, MEM_WORD, 32'h44, 32'h0, 1'b0));

        drain();
        plv = 2'd3; // user mode from here on.
        send(build(MEM_LOAD, MEM_WORD, 32'h400, 32'h0, 1'b0));
        send(build(MEM_STORE, MEM_BYTE, 32'h1000_0001, 32'h55, 1'b0));
        send(build(MEM_LOAD, MEM_HALF, 32'h382, 32'h0, 1'b0));
        send(build(MEM_STORE, MEM_WORD, 32'h3bc, 32'h1234_5678, 1'b0));
        send(build(MEM_LOAD, MEM_BYTE, 32'h27f, 32'h0, 1'b1));
        send(build(MEM_STORE, MEM_WORD, 32'h210, 32'hcafe_f00d, 1'b0));
        send(build(MEM_STORE, MEM_HALF, 32'h33e, 32'hbeef, 1'b0));
        send(build(MEM_LOAD, MEM_WORD, 32'h386, 32'h0, 1'b0));
        send(build(MEM_STORE, MEM_HALF, 32'h402, 32'h0, 1'b0));
        send(build(MEM_STORE, MEM_WORD, 32'h3c0, 32'h0bad_c0de, 1'b0));
        send(build(MEM_LOAD, MEM_BYTE, 32'h1ff, 32'h0, 1'b0));
        d = build(MEM_LOAD, MEM_WORD, 32'h44, 32'h0, 1'b0);
        d.have_exception = 1'b1;
        d.exception_type = PME;
        send(d);
        drain();
        plv = 2'd0;
        send(build(MEM_STORE, MEM_HALF, 32'h33e, 32'hbeef, 1'b0));
        send(build(MEM_LOAD, MEM_WORD, 32'h210, 32'h0, 1'b0));
        send(build(MEM_LOAD, MEM_WORD, 32'h3c0, 32'h0, 1'b0));

        for (int i = 0; i < 3; i++) begin
            send(build(MEM_NOP, MEM_WORD, $urandom, $urandom, 1'b0));
        end

        drain();
        ready_pct = 0;
        @(negedge clk);
        send(build(MEM_LOAD, MEM_WORD, 32'h48, 32'h0, 1'b0));
        send(build(MEM_LOAD, MEM_BYTE, 32'h4d, 32'h0, 1'b1));
        assert (wb_valid && !ex_allowin) else begin
            flow_errors++;
            $display("the pipeline did not hold both instructions under back-pressure");
        end
        flush_pipe();
        ready_pct = 100;
        send(build(MEM_LOAD, MEM_HALF, 32'h4a, 32'h0, 1'b0));

        ready_pct = 60;
        for (int i = 0; i < N_RANDOM; i++) begin
            d = build(mem_type_t'($urandom_range(2)), mem_size_t'($urandom_range(2)),
                      $urandom_range(32'h2ff), $urandom, 1'($urandom_range(1)));
            send(d);
            if ($urandom_range(3) == 0) begin
                @(negedge clk); // bubble on the execute side.
            end
        end

        ready_pct = 80;
        for (int i = 0; i < N_FILL; i++) begin
            send(build(MEM_LOAD, MEM_WORD, 4 * i, 32'h0, 1'b0));
        end
        drain();
        @(negedge clk);

        $display("errors: value %0d, flow %0d, assertion %0d", value_errors, flow_errors,
                 u_dut.u_mem_stage.u_sva.fail_count);
        if (value_errors + flow_errors + u_dut.u_mem_stage.u_sva.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/lsu_isa_pkg.sv
hw/lsu_pipe_pkg.sv
hw/pipe_reg.sv
hw/addr_check.sv
hw/data_ram.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/lsu_top.sv
sim/lsu_sva.sv
sim/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - hw/lsu_isa_pkg.sv
  - hw/lsu_pipe_pkg.sv
  - hw/pipe_reg.sv
  - hw/addr_check.sv
  - hw/data_ram.sv
  - hw/mem_stage.sv
  - hw/wb_stage.sv
  - hw/lsu_top.sv
  - target: test
    files:
      - sim/lsu_sva.sv
      - sim/lsu_tb.sv
